//--- logic/core_pkg.sv
// Shared types for the accumulator core: widths, opcodes, controller states
// and the packed structs that travel between the units. Imported by every RTL file.
package core_pkg;

  // Data and instruction word
  typedef logic [15:0] word_t;
  // Word address into the 256-entry memory
  typedef logic [7:0]  addr_t;

  // Opcode lives in instr[15:13], immediate or address in instr[7:0]
  typedef enum logic [2:0] {
    OP_NOP   = 3'd0,
    OP_ADDI  = 3'd1,
    OP_LOAD  = 3'd2,
    OP_STORE = 3'd3,
    OP_JUMP  = 3'd4,
    OP_BEQZ  = 3'd5,
    OP_HALT  = 3'd6
  } opcode_t;

  typedef enum logic [2:0] {
    RESET, BOOT_SET, RUN, DEBUG_TAKEN, HALTED
  } ctrl_state_e;

  typedef enum logic [1:0] {
    PC_BOOT, PC_JUMP, PC_BRANCH, PC_RESUME
  } pc_mux_e;

  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    addr_t   pc_target;
    logic    kill_if;
    logic    kill_ex;
    logic    halt_ex;
    logic    debug_halted;
  } ctrl_fsm_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    word_t rdata;
  } mem_rsp_t;

  // Requester side uses the same fields as the memory request
  typedef mem_req_t unit_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
  } unit_rsp_t;

  typedef struct packed {
    logic  retire;
    logic  jump;
    logic  branch_taken;
    logic  halt;
    addr_t target;
  } ex_event_t;

endpackage

//--- logic/shared_mem.sv
// Word memory behind the arbiter. Every accepted request is answered one
// cycle later together with one returned credit; the program is loaded in RESET.
`timescale 1ns/1ns

module shared_mem
  import core_pkg::*;
#(
  parameter int MEM_CREDITS = 2
) (
  input  logic     clk,
  input  logic     arst_n_i,
  input  mem_req_t req_i,
  input  logic     prog_we_i,
  input  addr_t    prog_addr_i,
  input  word_t    prog_data_i,
  input  logic     load_en_i,
  output mem_rsp_t rsp_o,
  output logic     mem_credit_o
);

  localparam int CW = $clog2(MEM_CREDITS + 1);

  word_t          mem [256];
  word_t          rdata_q;
  logic           rsp_valid_q;
  // Requests accepted but not yet answered
  logic [CW-1:0]  pending_q;

  // Storage, read pipeline and program load port
  always_ff @(posedge clk) begin
    if (load_en_i && prog_we_i) begin
      mem[prog_addr_i] <= prog_data_i;
    end else if (req_i.valid && req_i.write) begin
      mem[req_i.addr] <= req_i.wdata;
    end
    // Stores also answer, with the old word
    if (req_i.valid) begin
      rdata_q <= mem[req_i.addr];
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
      pending_q   <= '0;
    end else begin
      rsp_valid_q <= req_i.valid;
      pending_q   <= pending_q + CW'(req_i.valid) - CW'(mem_credit_o);
    end
  end

  assign rsp_o.valid  = rsp_valid_q;
  assign rsp_o.rdata  = rdata_q;
  // One credit goes back with each response
  assign mem_credit_o = rsp_valid_q;

  // Arbiter must never run ahead of the credits it was given
  a_mem_credit_limit :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     pending_q <= CW'(MEM_CREDITS))
      else $error("shared_mem: more than MEM_CREDITS requests outstanding");

endmodule

//--- logic/mem_arbiter.sv
// Fixed-priority arbiter between LSU and fetch in front of the shared memory.
// Holds the memory credit counter and steers each response back to its requester.
`timescale 1ns/1ns

module mem_arbiter
  import core_pkg::*;
#(
  parameter int MEM_CREDITS = 2
) (
  input  logic      clk,
  input  logic      arst_n_i,
  input  unit_req_t lsu_req_i,
  input  unit_req_t fetch_req_i,
  input  mem_rsp_t  mem_rsp_i,
  input  logic      mem_credit_i,
  output unit_rsp_t lsu_rsp_o,
  output unit_rsp_t fetch_rsp_o,
  output mem_req_t  mem_req_o
);

  localparam int CW = $clog2(MEM_CREDITS + 1);
  localparam int PW = (MEM_CREDITS > 1) ? $clog2(MEM_CREDITS) : 1;

  logic [CW-1:0] credit_q;
  logic          has_credit;
  logic          gnt_lsu;
  logic          gnt_fetch;
  logic          issue;

  // Order queue of requester ids, 1 marks the LSU
  logic          id_q [MEM_CREDITS];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] id_cnt_q;
  logic          head_lsu;

  //////////////////////////////////////////////////////////////////////
  // Grant
  //////////////////////////////////////////////////////////////////////

  assign has_credit = (credit_q != '0);
  // LSU wins a tie
  assign gnt_lsu    = lsu_req_i.valid && has_credit;
  assign gnt_fetch  = fetch_req_i.valid && !lsu_req_i.valid && has_credit;
  assign issue      = gnt_lsu || gnt_fetch;

  always_comb begin
    mem_req_o       = gnt_lsu ? lsu_req_i : fetch_req_i;
    mem_req_o.valid = issue;
  end

  //////////////////////////////////////////////////////////////////////
  // Credits and response routing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_q <= CW'(MEM_CREDITS);
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      id_cnt_q <= '0;
    end else begin
      credit_q <= credit_q - CW'(issue) + CW'(mem_credit_i);
      id_cnt_q <= id_cnt_q + CW'(issue) - CW'(mem_rsp_i.valid);
      if (issue) begin
        wr_ptr_q <= (wr_ptr_q == PW'(MEM_CREDITS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (mem_rsp_i.valid) begin
        rd_ptr_q <= (rd_ptr_q == PW'(MEM_CREDITS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      id_q[wr_ptr_q] <= gnt_lsu;
    end
  end

  assign head_lsu = id_q[rd_ptr_q];

  assign lsu_rsp_o.gnt      = gnt_lsu;
  assign lsu_rsp_o.rvalid   = mem_rsp_i.valid && head_lsu;
  assign lsu_rsp_o.rdata    = mem_rsp_i.rdata;
  assign fetch_rsp_o.gnt    = gnt_fetch;
  assign fetch_rsp_o.rvalid = mem_rsp_i.valid && !head_lsu;
  assign fetch_rsp_o.rdata  = mem_rsp_i.rdata;

  a_credit_bound :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     credit_q <= CW'(MEM_CREDITS))
      else $error("mem_arbiter: credit count above MEM_CREDITS");

  // A grant needs room for one more response, i.e. a credit really free
  a_gnt_needs_credit :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     (lsu_rsp_o.gnt || fetch_rsp_o.gnt) |-> (id_cnt_q < CW'(MEM_CREDITS)))
      else $error("mem_arbiter: grant given without a free credit");

endmodule

//--- logic/fetch_unit.sv
// Instruction fetch: program counter, credit-limited request issue and a
// two-entry instruction buffer. Stale responses are dropped by epoch.
`timescale 1ns/1ns

module fetch_unit
  import core_pkg::*;
#(
  parameter addr_t BOOT_ADDR = '0
) (
  input  logic      clk,
  input  logic      arst_n_i,
  input  ctrl_fsm_t ctrl_i,
  input  unit_rsp_t rsp_i,
  input  logic      instr_pop_i,
  output unit_req_t req_o,
  output word_t     instr_o,
  output addr_t     instr_pc_o,
  output logic      instr_valid_o
);

  addr_t       pc_q;
  logic [1:0]  epoch_q;
  // Fetch stays idle until the first pc_set from the controller
  logic        run_q;
  logic [1:0]  buf_cnt_q;
  logic [1:0]  infl_cnt_q;
  logic        push;

  // In-flight tags, in request order
  logic [1:0]  tag_epoch [2];
  addr_t       tag_pc [2];
  logic        tag_wr_q;
  logic        tag_rd_q;

  // Instruction buffer
  word_t       buf_instr [2];
  addr_t       buf_pc [2];
  logic        buf_wr_q;
  logic        buf_rd_q;

  // Buffered plus outstanding must stay below the two buffer credits
  assign req_o.valid = run_q && (({1'b0, buf_cnt_q} + {1'b0, infl_cnt_q}) < 3'd2);
  assign req_o.write = 1'b0;
  assign req_o.addr  = pc_q;
  assign req_o.wdata = '0;

  // Keep only responses of the current epoch
  assign push = rsp_i.rvalid && (tag_epoch[tag_rd_q] == epoch_q) && !ctrl_i.kill_if;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q       <= BOOT_ADDR;
      epoch_q    <= '0;
      run_q      <= 1'b0;
      buf_cnt_q  <= '0;
      infl_cnt_q <= '0;
      tag_wr_q   <= 1'b0;
      tag_rd_q   <= 1'b0;
      buf_wr_q   <= 1'b0;
      buf_rd_q   <= 1'b0;
    end else begin
      if (ctrl_i.pc_set) begin
        pc_q  <= ctrl_i.pc_target;
        run_q <= 1'b1;
      end else if (rsp_i.gnt) begin
        pc_q <= pc_q + 1'b1;
      end
      infl_cnt_q <= infl_cnt_q + 2'(rsp_i.gnt) - 2'(rsp_i.rvalid);
      tag_wr_q   <= tag_wr_q ^ rsp_i.gnt;
      tag_rd_q   <= tag_rd_q ^ rsp_i.rvalid;
      if (ctrl_i.kill_if) begin
        epoch_q   <= epoch_q + 1'b1;
        buf_cnt_q <= '0;
        buf_wr_q  <= 1'b0;
        buf_rd_q  <= 1'b0;
      end else begin
        buf_cnt_q <= buf_cnt_q + 2'(push) - 2'(instr_pop_i);
        buf_wr_q  <= buf_wr_q ^ push;
        buf_rd_q  <= buf_rd_q ^ instr_pop_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_i.gnt) begin
      tag_epoch[tag_wr_q] <= epoch_q;
      tag_pc[tag_wr_q]    <= pc_q;
    end
    if (push) begin
      buf_instr[buf_wr_q] <= rsp_i.rdata;
      buf_pc[buf_wr_q]    <= tag_pc[tag_rd_q];
    end
  end

  assign instr_valid_o = (buf_cnt_q != '0);
  assign instr_o       = buf_instr[buf_rd_q];
  assign instr_pc_o    = buf_pc[buf_rd_q];

endmodule

//--- logic/lsu.sv
// Load/store unit. Runs one memory access for execute at a time: holds the
// request until grant, then completes on grant (store) or on the response (load).
`timescale 1ns/1ns

module lsu
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n_i,
  input  logic      start_i,
  input  logic      write_i,
  input  addr_t     addr_i,
  input  word_t     wdata_i,
  input  unit_rsp_t rsp_i,
  output unit_req_t req_o,
  output logic      done_o,
  output word_t     rdata_o,
  output logic      busy_o
);

  typedef enum logic [1:0] {LSU_IDLE, LSU_REQ, LSU_WAIT} lsu_state_e;

  lsu_state_e state_q;
  logic       write_q;
  addr_t      addr_q;
  word_t      wdata_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= LSU_IDLE;
    end else begin
      case (state_q)
        LSU_IDLE: if (start_i) state_q <= LSU_REQ;
        // Stores finish on grant, loads wait for data
        LSU_REQ:  if (rsp_i.gnt) state_q <= write_q ? LSU_IDLE : LSU_WAIT;
        LSU_WAIT: if (rsp_i.rvalid) state_q <= LSU_IDLE;
        default:  state_q <= LSU_IDLE;
      endcase
    end
  end

  // Access fields, captured at start
  always_ff @(posedge clk) begin
    if (start_i) begin
      write_q <= write_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  assign req_o.valid = (state_q == LSU_REQ);
  assign req_o.write = write_q;
  assign req_o.addr  = addr_q;
  assign req_o.wdata = wdata_q;

  assign done_o  = ((state_q == LSU_REQ) && rsp_i.gnt && write_q) ||
                   ((state_q == LSU_WAIT) && rsp_i.rvalid);
  assign rdata_o = rsp_i.rdata;
  assign busy_o  = (state_q != LSU_IDLE);

  // Execute must hold off until the previous access is done
  a_no_start_while_busy :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     start_i |-> !busy_o)
      else $error("lsu: start while an access is in progress");

endmodule

//--- logic/exec_stage.sv
// Execute stage: takes one instruction from the fetch buffer, owns the
// accumulator and reports each retirement with its control-flow effect.
`timescale 1ns/1ns

module exec_stage
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n_i,
  input  ctrl_fsm_t ctrl_i,
  input  word_t     instr_i,
  input  addr_t     instr_pc_i,
  input  logic      instr_valid_i,
  input  logic      lsu_done_i,
  input  word_t     lsu_rdata_i,
  input  logic      lsu_busy_i,
  output logic      instr_pop_o,
  output logic      lsu_start_o,
  output logic      lsu_write_o,
  output addr_t     lsu_addr_o,
  output word_t     lsu_wdata_o,
  output ex_event_t event_o,
  output addr_t     next_pc_o,
  output logic      busy_o,
  output word_t     acc_o,
  output logic      wb_valid_o
);

  opcode_t op_in;
  logic    is_mem;
  logic    take;
  logic    retire;

  logic    ex_valid_q;
  // Waiting for the LSU to report done
  logic    ex_wait_q;
  opcode_t ex_op_q;
  addr_t   ex_arg_q;
  addr_t   ex_pc_q;
  word_t   acc_q;

  assign op_in  = opcode_t'(instr_i[15:13]);
  assign is_mem = (op_in == OP_LOAD) || (op_in == OP_STORE);

  // One instruction at a time
  assign take   = instr_valid_i && !ctrl_i.halt_ex && !ctrl_i.kill_ex &&
                  !ex_valid_q && !lsu_busy_i;
  assign retire = ex_valid_q && !ex_wait_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_q <= 1'b0;
      ex_wait_q  <= 1'b0;
      acc_q      <= '0;
    end else begin
      if (take) begin
        ex_valid_q <= 1'b1;
        ex_wait_q  <= is_mem;
        // ADDI writes at take so acc_o is current in the retire cycle
        if (op_in == OP_ADDI) begin
          acc_q <= acc_q + {8'h00, instr_i[7:0]};
        end
      end else if (retire || ctrl_i.kill_ex) begin
        ex_valid_q <= 1'b0;
      end
      if (lsu_done_i) begin
        ex_wait_q <= 1'b0;
        if (ex_op_q == OP_LOAD) begin
          acc_q <= lsu_rdata_i;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      ex_op_q  <= op_in;
      ex_arg_q <= instr_i[7:0];
      ex_pc_q  <= instr_pc_i;
    end
  end

  assign instr_pop_o = take;
  assign lsu_start_o = take && is_mem;
  assign lsu_write_o = (op_in == OP_STORE);
  assign lsu_addr_o  = instr_i[7:0];
  assign lsu_wdata_o = acc_q;

  // Control-flow report, branch decided on the accumulator at retire
  assign event_o.retire       = retire;
  assign event_o.jump         = retire && (ex_op_q == OP_JUMP);
  assign event_o.branch_taken = retire && (ex_op_q == OP_BEQZ) && (acc_q == '0);
  assign event_o.halt         = retire && (ex_op_q == OP_HALT);
  assign event_o.target       = ex_arg_q;

  assign next_pc_o  = (event_o.jump || event_o.branch_taken) ? ex_arg_q : ex_pc_q + 1'b1;
  assign busy_o     = ex_valid_q;
  assign acc_o      = acc_q;
  assign wb_valid_o = retire;

endmodule

//--- logic/core_controller.sv
// Boot, run and debug FSM of the core. Drives program counter selection,
// kill and halt signals and keeps the resume address.
`timescale 1ns/1ns

module core_controller
  import core_pkg::*;
#(
  parameter addr_t BOOT_ADDR = '0
) (
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        boot_i,
  input  logic        debug_req_i,
  input  logic        debug_resume_i,
  input  ex_event_t   event_i,
  input  addr_t       next_pc_i,
  input  logic        ex_busy_i,
  input  logic        instr_valid_i,
  output ctrl_fsm_t   ctrl_o,
  output ctrl_state_e state_o,
  output logic        halted_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  addr_t       resume_q;
  logic        redirect;
  logic        jump_set;

  // Retirements that leave the fetched stream behind them stale
  assign redirect = event_i.jump || event_i.branch_taken || event_i.halt;

  //////////////////////////////////////////////////////////////////////
  // Next state and control outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    ctrl_o  = '0;
    ctrl_o.pc_mux = PC_BOOT;
    case (state_q)
      // Everything quiet while the program is loaded
      RESET: begin
        if (boot_i) state_d = BOOT_SET;
      end
      BOOT_SET: begin
        ctrl_o.pc_set    = 1'b1;
        ctrl_o.pc_mux    = PC_BOOT;
        ctrl_o.pc_target = BOOT_ADDR;
        ctrl_o.kill_if   = 1'b1;
        ctrl_o.halt_ex   = 1'b1;
        state_d          = RUN;
      end
      RUN: begin
        ctrl_o.kill_if = redirect;
        ctrl_o.kill_ex = redirect;
        ctrl_o.halt_ex = debug_req_i;
        if (event_i.jump || event_i.branch_taken) begin
          ctrl_o.pc_set    = 1'b1;
          ctrl_o.pc_mux    = event_i.jump ? PC_JUMP : PC_BRANCH;
          ctrl_o.pc_target = event_i.target;
        end
        if (event_i.halt || debug_req_i) state_d = DEBUG_TAKEN;
      end
      // Drain execute while any redirect lands in the resume address
      DEBUG_TAKEN: begin
        ctrl_o.kill_if = redirect;
        ctrl_o.kill_ex = redirect;
        ctrl_o.halt_ex = 1'b1;
        if (!ex_busy_i) state_d = HALTED;
      end
      HALTED: begin
        ctrl_o.debug_halted = 1'b1;
        ctrl_o.halt_ex      = 1'b1;
        if (debug_resume_i) begin
          ctrl_o.pc_set    = 1'b1;
          ctrl_o.pc_mux    = PC_RESUME;
          ctrl_o.pc_target = resume_q;
          ctrl_o.kill_if   = 1'b1;
          state_d          = RUN;
        end
      end
      default: state_d = RESET;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= RESET;
      resume_q <= BOOT_ADDR;
    end else begin
      state_q <= state_d;
      // Address after the last retired instruction
      if (event_i.retire) resume_q <= next_pc_i;
    end
  end

  assign state_o  = state_q;
  assign halted_o = (state_q == HALTED);

  //////////////////////////////////////////////////////////////////////
  // Pipeline rules
  //////////////////////////////////////////////////////////////////////

  assign jump_set = ctrl_o.pc_set &&
                    ((ctrl_o.pc_mux == PC_JUMP) || (ctrl_o.pc_mux == PC_BRANCH));

  // Flush after a redirect leaves nothing to redirect again next cycle
  a_no_back_to_back_jump :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     jump_set |=> !jump_set)
      else $error("controller: two jumps or branches back to back");

  a_kill_ex :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     ctrl_o.kill_ex |=> !event_i.retire)
      else $error("controller: retirement right after kill_ex");

  // Fetch and execute stay empty until boot has set the PC
  a_reset_no_instr :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     ((state_q == RESET) || (state_q == BOOT_SET)) |->
                     (!instr_valid_i && !ex_busy_i))
      else $error("controller: instruction valid during RESET or BOOT_SET");

  // A debug halted core has nothing left in execute
  a_debug_halted_idle :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     ctrl_o.debug_halted |-> !ex_busy_i)
      else $error("controller: execute busy while debug halted");

  a_no_retire_halted :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     halted_o |-> !event_i.retire)
      else $error("controller: retirement while halted");

endmodule

//--- logic/mini_core_top.sv
// Top level of the accumulator core. Connects fetch, LSU, arbiter, memory,
// execute and controller, and passes the parameters down.
`timescale 1ns/1ns

module mini_core_top
  import core_pkg::*;
#(
  parameter int    MEM_CREDITS = 2,
  parameter addr_t BOOT_ADDR   = '0
) (
  input  logic  clk,
  input  logic  arst_n_i,
  input  logic  boot_i,
  input  logic  debug_req_i,
  input  logic  debug_resume_i,
  input  logic  prog_we_i,
  input  addr_t prog_addr_i,
  input  word_t prog_data_i,
  output word_t acc_o,
  output logic  wb_valid_o,
  output logic  halted_o
);

  ctrl_fsm_t   ctrl;
  ctrl_state_e state;
  ex_event_t   ex_event;
  addr_t       next_pc;
  logic        ex_busy;

  unit_req_t   fetch_req;
  unit_rsp_t   fetch_rsp;
  unit_req_t   lsu_req;
  unit_rsp_t   lsu_rsp;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  logic        mem_credit;
  logic        load_en;

  word_t       instr;
  addr_t       instr_pc;
  logic        instr_valid;
  logic        instr_pop;

  logic        lsu_start;
  logic        lsu_write;
  addr_t       lsu_addr;
  word_t       lsu_wdata;
  logic        lsu_done;
  word_t       lsu_rdata;
  logic        lsu_busy;

  // Program load only while waiting for boot
  assign load_en = (state == RESET);

  shared_mem #(.MEM_CREDITS(MEM_CREDITS)) u_mem (
    .clk, .arst_n_i,
    .req_i(mem_req), .prog_we_i, .prog_addr_i, .prog_data_i,
    .load_en_i(load_en), .rsp_o(mem_rsp), .mem_credit_o(mem_credit)
  );

  mem_arbiter #(.MEM_CREDITS(MEM_CREDITS)) u_arb (
    .clk, .arst_n_i,
    .lsu_req_i(lsu_req), .fetch_req_i(fetch_req),
    .mem_rsp_i(mem_rsp), .mem_credit_i(mem_credit),
    .lsu_rsp_o(lsu_rsp), .fetch_rsp_o(fetch_rsp), .mem_req_o(mem_req)
  );

  fetch_unit #(.BOOT_ADDR(BOOT_ADDR)) u_fetch (
    .clk, .arst_n_i,
    .ctrl_i(ctrl), .rsp_i(fetch_rsp), .instr_pop_i(instr_pop),
    .req_o(fetch_req), .instr_o(instr), .instr_pc_o(instr_pc),
    .instr_valid_o(instr_valid)
  );

  lsu u_lsu (
    .clk, .arst_n_i,
    .start_i(lsu_start), .write_i(lsu_write), .addr_i(lsu_addr),
    .wdata_i(lsu_wdata), .rsp_i(lsu_rsp),
    .req_o(lsu_req), .done_o(lsu_done), .rdata_o(lsu_rdata), .busy_o(lsu_busy)
  );

  exec_stage u_ex (
    .clk, .arst_n_i,
    .ctrl_i(ctrl), .instr_i(instr), .instr_pc_i(instr_pc),
    .instr_valid_i(instr_valid), .lsu_done_i(lsu_done),
    .lsu_rdata_i(lsu_rdata), .lsu_busy_i(lsu_busy),
    .instr_pop_o(instr_pop), .lsu_start_o(lsu_start), .lsu_write_o(lsu_write),
    .lsu_addr_o(lsu_addr), .lsu_wdata_o(lsu_wdata), .event_o(ex_event),
    .next_pc_o(next_pc), .busy_o(ex_busy), .acc_o, .wb_valid_o
  );

  core_controller #(.BOOT_ADDR(BOOT_ADDR)) u_ctrl (
    .clk, .arst_n_i,
    .boot_i, .debug_req_i, .debug_resume_i,
    .event_i(ex_event), .next_pc_i(next_pc), .ex_busy_i(ex_busy),
    .instr_valid_i(instr_valid),
    .ctrl_o(ctrl), .state_o(state), .halted_o
  );

endmodule

//--- bench/tb_mini_core.sv
// Testbench for the accumulator core. Loads small programs through the load port,
// predicts each retirement with a golden model and checks it with assertions.
`timescale 1ns/1ns

module tb_mini_core
  import core_pkg::*;
;

  localparam int WAIT_LIMIT = 400;
  localparam int MAX_ROUNDS = 8;

  logic  clk = 1'b0;
  logic  arst_n_i;
  logic  boot_i;
  logic  debug_req_i;
  logic  debug_resume_i;
  logic  prog_we_i;
  addr_t prog_addr_i;
  word_t prog_data_i;
  word_t acc_o;
  logic  wb_valid_o;
  logic  halted_o;

  // Program image and golden model state
  word_t       prog [64];
  int          prog_len;
  word_t       model_mem [256];
  word_t       exp_acc [64];
  logic [7:0]  exp_cnt;
  logic [7:0]  exp_idx;
  word_t       exp_now;
  logic [31:0] lfsr_q;
  logic        booted;
  string       test_name;

  // Error counts, one per driving process
  int chk_errs;
  int flow_errs;
  int tests_run;
  int tests_failed;

  always #20 clk = ~clk;

  mini_core_top #(
    .MEM_CREDITS(2),
    .BOOT_ADDR(8'h00)
  ) UUT (
    .clk, .arst_n_i, .boot_i, .debug_req_i, .debug_resume_i,
    .prog_we_i, .prog_addr_i, .prog_data_i,
    .acc_o, .wb_valid_o, .halted_o
  );

  //////////////////////////////////////////////////////////////////////
  // Retirement tracking and checks
  //////////////////////////////////////////////////////////////////////

  // Index of the next predicted retirement
  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exp_idx <= '0;
    end else if (wb_valid_o) begin
      exp_idx <= exp_idx + 8'd1;
    end
  end

  assign exp_now = exp_acc[exp_idx[5:0]];

  a_idle_before_boot :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     !booted |-> (!wb_valid_o && !halted_o))
      else begin
        $display("CHECK FAILED %s: expected wb_valid_o/halted_o 0/0, actual %b/%b",
                 test_name, $sampled(wb_valid_o), $sampled(halted_o));
        chk_errs++;
      end

  a_acc_match :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     wb_valid_o |-> (acc_o == exp_now))
      else begin
        $display("CHECK FAILED %s: retirement %0d expected acc %h, actual %h",
                 test_name, $sampled(exp_idx), $sampled(exp_now), $sampled(acc_o));
        chk_errs++;
      end

  // Skipped instructions would show up as extra retirements
  a_retire_in_model :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     wb_valid_o |-> (exp_idx < exp_cnt))
      else begin
        $display("ERROR %s: the core retired more instructions than the model predicts",
                 test_name);
        chk_errs++;
      end

  a_no_retire_halted :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     halted_o |-> !wb_valid_o)
      else begin
        $display("ERROR %s: an instruction retired while halted_o was high", test_name);
        chk_errs++;
      end

  //////////////////////////////////////////////////////////////////////
  // Program generation and golden model
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per random bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic rand_byte(output addr_t v);
    v = '0;
    for (int k = 0; k < 8; k++) begin
      v = {v[6:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Opcode on top, argument in the low byte
  function automatic word_t encode(input opcode_t op, input addr_t arg);
    encode = {op, 5'b00000, arg};
  endfunction

  task automatic put(input opcode_t op, input addr_t arg);
    prog[prog_len[5:0]] = encode(op, arg);
    prog_len++;
  endtask

  task automatic put_rand_addi();
    addr_t imm;
    rand_byte(imm);
    put(OP_ADDI, imm);
  endtask

  // Walks the program in order; only the HALT in the last word ends it
  task automatic build_model();
    addr_t   pc;
    word_t   acc;
    word_t   ins;
    opcode_t op;
    int      steps;
    pc      = 8'h00;
    acc     = '0;
    exp_cnt = '0;
    steps   = 0;
    for (int i = 0; i < 256; i++) begin
      model_mem[i[7:0]] = (i < prog_len) ? prog[i[5:0]] : '0;
    end
    while (steps < 64) begin
      ins = model_mem[pc];
      op  = opcode_t'(ins[15:13]);
      case (op)
        OP_ADDI:  acc = acc + {8'h00, ins[7:0]};
        OP_LOAD:  acc = model_mem[ins[7:0]];
        OP_STORE: model_mem[ins[7:0]] = acc;
        default:  ;
      endcase
      exp_acc[exp_cnt[5:0]] = acc;
      exp_cnt = exp_cnt + 8'd1;
      steps++;
      if (op == OP_HALT && pc == 8'(prog_len - 1)) begin
        break;
      end
      // BEQZ looks at the accumulator after everything before it
      if (op == OP_JUMP || (op == OP_BEQZ && acc == '0)) begin
        pc = ins[7:0];
      end else begin
        pc = pc + 8'd1;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Inputs change 2 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic apply_reset();
    booted         = 1'b0;
    arst_n_i       = 1'b0;
    boot_i         = 1'b0;
    debug_req_i    = 1'b0;
    debug_resume_i = 1'b0;
    prog_we_i      = 1'b0;
    repeat (4) step();
    arst_n_i = 1'b1;
  endtask

  // Controller sits in RESET, so the load port is open
  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      prog_we_i   = 1'b1;
      prog_addr_i = i[7:0];
      prog_data_i = prog[i[5:0]];
      step();
    end
    prog_we_i = 1'b0;
  endtask

  // Returns on halt, or once the debug point is reached
  task automatic wait_stop(input int dbg_at, output logic timed_out);
    int n;
    n         = 0;
    timed_out = 1'b0;
    while (!halted_o && !(dbg_at >= 0 && int'(exp_idx) >= dbg_at)) begin
      if (n == WAIT_LIMIT) begin
        timed_out = 1'b1;
        break;
      end
      step();
      n++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (chk_errs + flow_errs == errs_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, chk_errs + flow_errs - errs_before);
    end
  endtask

  task automatic check_idle();
    int errs_before;
    errs_before = chk_errs + flow_errs;
    test_name   = "idle_before_boot";
    prog_len    = 0;
    exp_cnt     = '0;
    apply_reset();
    repeat (20) step();
    report_test(test_name, errs_before);
  endtask

  // Boots the loaded program, resumes after each halt until the model is done
  task automatic run_program(input string name, input int dbg_at);
    int   errs_before;
    int   pending_dbg;
    int   rounds;
    logic finished;
    logic timed_out;
    errs_before = chk_errs + flow_errs;
    test_name   = name;
    pending_dbg = dbg_at;
    rounds      = 0;
    finished    = 1'b0;
    apply_reset();
    load_program();
    build_model();
    repeat (3) step();
    boot_i = 1'b1;
    booted = 1'b1;
    step();
    boot_i = 1'b0;
    while (!finished && rounds < MAX_ROUNDS) begin
      wait_stop(pending_dbg, timed_out);
      if (timed_out) begin
        $display("ERROR %s: core did not halt within %0d cycles", name, WAIT_LIMIT);
        flow_errs++;
        finished = 1'b1;
      end else if (!halted_o) begin
        // Debug request in the middle of the run
        debug_req_i = 1'b1;
        step();
        debug_req_i = 1'b0;
        pending_dbg = -1;
      end else if (exp_idx >= exp_cnt) begin
        finished = 1'b1;
      end else begin
        debug_resume_i = 1'b1;
        step();
        debug_resume_i = 1'b0;
      end
      rounds++;
    end
    if (!finished) begin
      $display("ERROR %s: program did not finish within %0d halts", name, MAX_ROUNDS);
      flow_errs++;
    end
    assert (exp_idx == exp_cnt) else begin
      $display("CHECK FAILED %s: expected %0d retirements, actual %0d",
               name, exp_cnt, exp_idx);
      flow_errs++;
    end
    report_test(name, errs_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    arst_n_i       = 1'b0;
    boot_i         = 1'b0;
    debug_req_i    = 1'b0;
    debug_resume_i = 1'b0;
    prog_we_i      = 1'b0;
    prog_addr_i    = '0;
    prog_data_i    = '0;
    booted         = 1'b0;
    lfsr_q         = 32'h9f306229;
    exp_cnt        = '0;
    chk_errs       = 0;
    flow_errs      = 0;
    tests_run      = 0;
    tests_failed   = 0;
    test_name      = "none";

    check_idle();

    // Straight line of random increments
    prog_len = 0;
    repeat (12) put_rand_addi();
    put(OP_HALT, 8'h00);
    run_program("addi_chain", -1);

    // Store and load back, with fetch competing for the memory
    prog_len = 0;
    put_rand_addi();
    put(OP_STORE, 8'hF0);
    put_rand_addi();
    put_rand_addi();
    put(OP_LOAD, 8'hF0);
    put_rand_addi();
    put(OP_STORE, 8'hF1);
    put_rand_addi();
    put(OP_LOAD, 8'hF1);
    put(OP_LOAD, 8'hF0);
    put(OP_HALT, 8'h00);
    run_program("store_load", -1);

    // Taken BEQZ at 0, untaken BEQZ at 4, JUMP at 5
    prog_len = 0;
    put(OP_BEQZ, 8'h03);
    put(OP_ADDI, 8'h11);
    put(OP_ADDI, 8'h22);
    put(OP_ADDI, 8'h05);
    put(OP_BEQZ, 8'h07);
    put(OP_JUMP, 8'h08);
    put(OP_ADDI, 8'h33);
    put(OP_ADDI, 8'h44);
    put(OP_ADDI, 8'h01);
    put(OP_HALT, 8'h00);
    run_program("jump_branch", -1);

    // HALT in the middle, then a debug request after five retirements
    prog_len = 0;
    put_rand_addi();
    put_rand_addi();
    put(OP_HALT, 8'h00);
    repeat (4) put_rand_addi();
    put(OP_NOP, 8'h00);
    put_rand_addi();
    put_rand_addi();
    put(OP_HALT, 8'h00);
    run_program("halt_debug", 5);

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, chk_errs + flow_errs);
    if (tests_failed == 0 && chk_errs + flow_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- files.f
logic/core_pkg.sv
logic/shared_mem.sv
logic/mem_arbiter.sv
logic/fetch_unit.sv
logic/lsu.sv
logic/exec_stage.sv
logic/core_controller.sv
logic/mini_core_top.sv
bench/tb_mini_core.sv

//--- run.sh
#!/bin/sh
# Build the core and its testbench with Verilator, run it, and look for the pass line
verilator --binary --timing --assert -j 0 --top-module tb_mini_core -f files.f &&
  ./obj_dir/Vtb_mini_core | tee /dev/stderr | grep -x -F "PASS: all tests" > /dev/null &&
  echo "run.sh: simulation passed" ||
  { echo "run.sh: simulation failed"; exit 1; }
